/* verilog/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

  localparam int DC_INDEX_BITS_DEF = 4;  // 16 direct-mapped lines.

  typedef enum logic [2:0] {
    OP_LB  = 3'd0,
    OP_LBU = 3'd1,
    OP_LH  = 3'd2,
    OP_LHU = 3'd3,
    OP_LW  = 3'd4,
    OP_SB  = 3'd5,
    OP_SH  = 3'd6,
    OP_SW  = 3'd7
  } dc_op_e;

  typedef enum logic [2:0] {
    ST_IDLE     = 3'd0,
    ST_LOOKUP   = 3'd1,
    ST_MEM_REQ  = 3'd2,
    ST_MEM_WAIT = 3'd3,
    ST_ACK      = 3'd4,
    ST_RELEASE  = 3'd5
  } dc_state_e;

  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd2
  } dc_size_e;

  typedef struct packed {
    logic [31:0] addr;
    dc_op_e      op;
  } dc_req_t;

  typedef struct packed {
    logic [31:0] addr;
    logic        is_store;
    dc_size_e    size;
    logic        sx;          // Sign extend the load result.
    logic [3:0]  be;
    logic        misaligned;
  } dc_dec_t;

  typedef struct packed {
    logic [31:0] addr;   // Word address, byte address >> 2.
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
  } dc_mem_cmd_t;

endpackage

`default_nettype wire

/* verilog/dcache_decode.sv */
`default_nettype none

module dcache_decode import dcache_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  dc_req_t req,
  input  logic    cpu_req,
  input  logic    busy,
  output dc_dec_t dec,
  output logic    dec_valid
);

  logic    capture;
  dc_dec_t dec_next;

  assign capture = cpu_req && !busy;

  always_comb begin
    dec_next = '0;
    dec_next.addr = req.addr;
    case (req.op)
      OP_LB: begin
        dec_next.size = SZ_BYTE;
        dec_next.sx = 1'b1;
      end
      OP_LBU: dec_next.size = SZ_BYTE;
      OP_LH: begin
        dec_next.size = SZ_HALF;
        dec_next.sx = 1'b1;
      end
      OP_LHU: dec_next.size = SZ_HALF;
      OP_SB: begin
        dec_next.size = SZ_BYTE;
        dec_next.is_store = 1'b1;
      end
      OP_SH: begin
        dec_next.size = SZ_HALF;
        dec_next.is_store = 1'b1;
      end
      OP_SW: begin
        dec_next.size = SZ_WORD;
        dec_next.is_store = 1'b1;
      end
      default: dec_next.size = SZ_WORD;  // OP_LW.
    endcase
    case (dec_next.size)
      SZ_BYTE: dec_next.be = 4'b0001 << req.addr[1:0];
      SZ_HALF: dec_next.be = 4'b0011 << {req.addr[1], 1'b0};
      default: dec_next.be = 4'b1111;
    endcase
    dec_next.misaligned = (dec_next.size == SZ_HALF && req.addr[0]) ||
                          (dec_next.size == SZ_WORD && req.addr[1:0] != 2'b00);
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      dec <= dec_next;  // Held until the next capture.
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= capture;
    end
  end

endmodule

`default_nettype wire

/* verilog/dcache_ctrl.sv */
`default_nettype none

module dcache_ctrl import dcache_pkg::*; #(
  parameter int INDEX_BITS = DC_INDEX_BITS_DEF
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        disable_cache,
  input  logic        invalidate,
  input  dc_dec_t     dec,
  input  logic        dec_valid,
  input  logic        cpu_req,
  input  logic [31:0] store_data,
  input  logic [31:0] fill_data,
  output logic        busy,
  output logic        cpu_ack,
  output logic        cpu_err,
  output logic        miss,
  output logic        mem_req,
  output dc_mem_cmd_t mem_cmd,
  input  logic        mem_ack,
  output logic [31:0] ld_word,
  output dc_dec_t     ld_info,
  output logic        ld_drive,
  output logic        use_up_in
);

  localparam int LINES    = 1 << INDEX_BITS;
  localparam int TAG_BITS = 30 - INDEX_BITS;

  dc_state_e             state;
  logic [LINES-1:0]      valid;
  logic [TAG_BITS-1:0]   tag_arr [LINES];
  logic [31:0]           data_arr [LINES];
  logic [INDEX_BITS-1:0] index;
  logic [TAG_BITS-1:0]   tag;
  logic [31:0]           line_word;
  logic [31:0]           wdata_q;
  logic [31:0]           ld_q;
  logic                  hit;
  logic                  fill_en;
  logic                  store_hit;
  logic                  mem_done;

  function automatic logic [31:0] lane_data(input logic [31:0] d, input dc_size_e size);
    case (size)
      SZ_BYTE: return {4{d[7:0]}};
      SZ_HALF: return {2{d[15:0]}};
      default: return d;
    endcase
  endfunction

  function automatic logic [31:0] merge_word(input logic [31:0] old_word,
                                             input logic [31:0] new_word,
                                             input logic [3:0]  be);
    logic [31:0] w;
    w = old_word;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        w[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return w;
  endfunction

  assign index     = dec.addr[2 +: INDEX_BITS];
  assign tag       = dec.addr[31 -: TAG_BITS];
  assign line_word = data_arr[index];
  assign hit       = valid[index] && (tag_arr[index] == tag);
  assign mem_done  = (state == ST_MEM_WAIT) && mem_ack;

  assign busy     = (state != ST_IDLE) || dec_valid;  // No capture while one is in flight.
  assign ld_word  = ld_q;
  assign ld_info  = dec;
  assign ld_drive = cpu_ack && !cpu_err && !dec.is_store;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      valid     <= '0;
      cpu_ack   <= 1'b0;
      cpu_err   <= 1'b0;
      miss      <= 1'b0;
      mem_req   <= 1'b0;
      use_up_in <= 1'b0;
      fill_en   <= 1'b0;
      store_hit <= 1'b0;
    end else begin
      miss <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (invalidate) begin
            valid <= '0;
          end
          if (dec_valid) begin
            state <= ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          fill_en   <= 1'b0;
          store_hit <= 1'b0;
          if (dec.misaligned) begin
            cpu_ack <= 1'b1;
            cpu_err <= 1'b1;
            state   <= ST_ACK;
          end else if (!dec.is_store && hit && !disable_cache) begin
            cpu_ack <= 1'b1;  // Load hit.
            state   <= ST_ACK;
          end else begin
            mem_req   <= 1'b1;
            miss      <= !dec.is_store && !disable_cache;
            fill_en   <= !dec.is_store && !disable_cache;
            store_hit <= dec.is_store && hit;
            state     <= ST_MEM_REQ;
          end
        end
        ST_MEM_REQ: state <= ST_MEM_WAIT;
        ST_MEM_WAIT: begin
          if (mem_ack) begin
            cpu_ack   <= 1'b1;
            use_up_in <= !dec.is_store;  // Memory keeps the word on the up bus.
            if (fill_en) begin
              valid[index] <= 1'b1;
            end
            state <= ST_ACK;
          end
        end
        ST_ACK: begin
          if (!cpu_req) begin
            cpu_ack   <= 1'b0;
            cpu_err   <= 1'b0;
            mem_req   <= 1'b0;
            use_up_in <= 1'b0;
            state     <= ST_RELEASE;
          end
        end
        ST_RELEASE: begin
          if (!mem_ack) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      wdata_q <= lane_data(store_data, dec.size);  // Replicate into byte lanes.
    end
    if (state == ST_LOOKUP) begin
      ld_q          <= line_word;
      mem_cmd.addr  <= {2'b00, dec.addr[31:2]};
      mem_cmd.we    <= dec.is_store;
      mem_cmd.be    <= dec.is_store ? dec.be : 4'b1111;
      mem_cmd.wdata <= wdata_q;
    end
    if (mem_done && fill_en) begin
      tag_arr[index]  <= tag;
      data_arr[index] <= fill_data;
    end
    if (mem_done && store_hit) begin
      data_arr[index] <= merge_word(line_word, wdata_q, dec.be);
    end
  end

endmodule

`default_nettype wire

/* verilog/dcache_bus_mux.sv */
`default_nettype none

module dcache_bus_mux import dcache_pkg::*; (
  input  logic [31:0] ld_word,
  input  dc_dec_t     ld_info,
  input  logic        ld_drive,
  input  logic        use_up_in,
  input  logic        bus_stall,
  input  logic [31:0] data_up_in,
  input  logic [31:0] data_down_in,
  output logic [31:0] data_up_out,
  output logic [31:0] data_down_out
);

  logic [31:0] raw_word;
  logic [31:0] shifted;
  logic [31:0] ld_result;
  logic        drive_down;

  // Memory loads take the word straight from the up bus.
  assign raw_word = use_up_in ? data_up_in : ld_word;

  assign shifted = raw_word >> {ld_info.addr[1:0], 3'b000};

  always_comb begin
    case (ld_info.size)
      SZ_BYTE: begin
        if (ld_info.sx) begin
          ld_result = {{24{shifted[7]}}, shifted[7:0]};
        end else begin
          ld_result = {24'h000000, shifted[7:0]};
        end
      end
      SZ_HALF: begin
        if (ld_info.sx) begin
          ld_result = {{16{shifted[15]}}, shifted[15:0]};
        end else begin
          ld_result = {16'h0000, shifted[15:0]};
        end
      end
      default: ld_result = raw_word;
    endcase
  end

  assign drive_down = ld_drive && !bus_stall;  // Stall holds the bus in passthrough.

  assign data_down_out = drive_down ? ld_result : data_down_in;

  // No upstream stores, so the up bus only passes through.
  assign data_up_out = data_up_in;

endmodule

`default_nettype wire

/* verilog/dcache_bus.sv */
`default_nettype none

module dcache_bus import dcache_pkg::*; #(
  parameter int INDEX_BITS = DC_INDEX_BITS_DEF
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        disable_cache,
  input  logic        invalidate,
  input  logic        cpu_req,
  input  dc_req_t     req,
  output logic        cpu_ack,
  output logic        cpu_err,
  output logic        miss,
  output logic        mem_req,
  output dc_mem_cmd_t mem_cmd,
  input  logic        mem_ack,
  input  logic        bus_stall,
  input  logic [31:0] data_up_in,
  output logic [31:0] data_up_out,
  input  logic [31:0] data_down_in,
  output logic [31:0] data_down_out
);

  dc_dec_t     dec;
  logic        dec_valid;
  logic        busy;
  logic [31:0] ld_word;
  dc_dec_t     ld_info;
  logic        ld_drive;
  logic        use_up_in;

  dcache_decode u_decode (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .cpu_req   (cpu_req),
    .busy      (busy),
    .dec       (dec),
    .dec_valid (dec_valid)
  );

  dcache_ctrl #(
    .INDEX_BITS (INDEX_BITS)
  ) u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .disable_cache (disable_cache),
    .invalidate    (invalidate),
    .dec           (dec),
    .dec_valid     (dec_valid),
    .cpu_req       (cpu_req),
    .store_data    (data_down_in),  // Store data rides the down bus.
    .fill_data     (data_up_in),    // Refill data comes back on the up bus.
    .busy          (busy),
    .cpu_ack       (cpu_ack),
    .cpu_err       (cpu_err),
    .miss          (miss),
    .mem_req       (mem_req),
    .mem_cmd       (mem_cmd),
    .mem_ack       (mem_ack),
    .ld_word       (ld_word),
    .ld_info       (ld_info),
    .ld_drive      (ld_drive),
    .use_up_in     (use_up_in)
  );

  dcache_bus_mux u_bus_mux (
    .ld_word       (ld_word),
    .ld_info       (ld_info),
    .ld_drive      (ld_drive),
    .use_up_in     (use_up_in),
    .bus_stall     (bus_stall),
    .data_up_in    (data_up_in),
    .data_down_in  (data_down_in),
    .data_up_out   (data_up_out),
    .data_down_out (data_down_out)
  );

endmodule

`default_nettype wire

/* dv/dcache_bus_props.sv */
`default_nettype none

module dcache_bus_props (
  input wire logic        clk,
  input wire logic        reset,
  input wire logic        cpu_req,
  input wire logic        cpu_ack,
  input wire logic        mem_req,
  input wire logic        mem_ack,
  input wire logic        bus_stall,
  input wire logic [31:0] data_down_in,
  input wire logic [31:0] data_down_out
);
  timeunit 1ns;
  timeprecision 100ps;

  assert property (@(posedge clk) disable iff (reset) cpu_ack && cpu_req |=> cpu_ack)
    else $error("cpu_ack dropped while cpu_req was still high");
  assert property (@(posedge clk) disable iff (reset) !cpu_ack && !cpu_req |=> !cpu_ack)
    else $error("cpu_ack rose with no request");
  assert property (@(posedge clk) disable iff (reset) $rose(cpu_req) |-> !cpu_ack)
    else $error("cpu_req rose while cpu_ack was still high");

  // Memory side follows the same four-phase rule.
  assert property (@(posedge clk) disable iff (reset) mem_req && !mem_ack |=> mem_req)
    else $error("mem_req dropped before mem_ack");
  assert property (@(posedge clk) disable iff (reset) !mem_req && mem_ack |=> !mem_req)
    else $error("mem_req rose while mem_ack was still high");

  assert property (@(posedge clk) disable iff (reset)
                   (bus_stall || !cpu_ack) |-> data_down_out == data_down_in)
    else $error("down bus driven outside a load ack");

endmodule

bind dcache_bus dcache_bus_props u_props (.*);

`default_nettype wire

/* dv/dcache_bus_tb.sv */
`default_nettype none

module dcache_bus_tb import dcache_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 4;
  localparam int MEM_WORDS  = 256;
  // About 40 accesses of at most 15 cycles each, plus reset and margin.
  localparam int WATCHDOG_CYCLES = 2000;

  logic        clk;
  logic        reset;
  logic        disable_cache;
  logic        invalidate;
  logic        cpu_req;
  dc_req_t     req;
  logic        cpu_ack;
  logic        cpu_err;
  logic        miss;
  logic        mem_req;
  dc_mem_cmd_t mem_cmd;
  logic        mem_ack;
  logic        bus_stall;
  logic [31:0] data_up_in;
  logic [31:0] data_up_out;
  logic [31:0] data_down_in;
  logic [31:0] data_down_out;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] up_bus;
  logic [31:0] mem_rdata;
  logic        mem_drive;
  logic [3:0]  last_be;
  logic [31:0] last_addr;
  integer      seed = 32'hc62e_f9cd;
  int          errors = 0;
  int          checks = 0;
  int          miss_count = 0;
  int          mem_reads = 0;
  int          mem_writes = 0;

  assign data_up_in = mem_drive ? mem_rdata : up_bus;  // Memory owns the up bus on reads.

  dcache_bus #(
    .INDEX_BITS (DC_INDEX_BITS_DEF)
  ) UUT (
    .clk           (clk),
    .reset         (reset),
    .disable_cache (disable_cache),
    .invalidate    (invalidate),
    .cpu_req       (cpu_req),
    .req           (req),
    .cpu_ack       (cpu_ack),
    .cpu_err       (cpu_err),
    .miss          (miss),
    .mem_req       (mem_req),
    .mem_cmd       (mem_cmd),
    .mem_ack       (mem_ack),
    .bus_stall     (bus_stall),
    .data_up_in    (data_up_in),
    .data_up_out   (data_up_out),
    .data_down_in  (data_down_in),
    .data_down_out (data_down_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    if (!reset && miss === 1'b1) begin
      miss_count++;
    end
  end

  initial begin
    dc_mem_cmd_t cmd;
    int          delay;
    mem_ack   = 1'b0;
    mem_drive = 1'b0;
    mem_rdata = '0;
    forever begin
      wait (mem_req === 1'b1);
      delay = $unsigned($random(seed)) % 4;
      repeat (delay + 1) @(posedge clk);
      #1;
      cmd       = mem_cmd;
      last_be   = cmd.be;
      last_addr = cmd.addr;
      if (cmd.we) begin
        for (int b = 0; b < 4; b++) begin
          if (cmd.be[b]) begin
            mem[cmd.addr[7:0]][8*b +: 8] = cmd.wdata[8*b +: 8];
          end
        end
        mem_writes++;
      end else begin
        mem_rdata = mem[cmd.addr[7:0]];
        mem_drive = 1'b1;
        mem_reads++;
      end
      mem_ack = 1'b1;
      wait (mem_req === 1'b0);
      @(posedge clk);
      #1;
      mem_ack   = 1'b0;
      mem_drive = 1'b0;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: no final result after %0d cycles", WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

  function automatic logic [31:0] fill_word(input int i);
    return (32'(i) * 32'h9e37_79b1) ^ 32'h5ac3_17e8;
  endfunction

  function automatic logic [31:0] expected_load(input dc_op_e op, input logic [31:0] addr,
                                                input logic [31:0] word);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[8*addr[1:0] +: 8];
    h = word[16*addr[1] +: 16];
    case (op)
      OP_LB:   return {{24{b[7]}}, b};
      OP_LBU:  return {24'h000000, b};
      OP_LH:   return {{16{h[15]}}, h};
      OP_LHU:  return {16'h0000, h};
      default: return word;
    endcase
  endfunction

  function automatic logic [3:0] expected_be(input dc_op_e op, input logic [31:0] addr);
    logic [3:0] be;
    be = '0;
    case (op)
      OP_SB:   be[addr[1:0]] = 1'b1;
      OP_SH:   be = addr[1] ? 4'b1100 : 4'b0011;
      default: be = 4'b1111;
    endcase
    return be;
  endfunction

  function automatic logic [31:0] merged_store(input dc_op_e op, input logic [31:0] addr,
                                               input logic [31:0] old_word,
                                               input logic [31:0] data);
    logic [31:0] w;
    w = old_word;
    case (op)
      OP_SB:   w[8*addr[1:0] +: 8] = data[7:0];
      OP_SH:   w[16*addr[1] +: 16] = data[15:0];
      default: w = data;
    endcase
    return w;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic end_test(input string name, input int start);
    $display("test %s finished with %0d errors", name, errors - start);
  endtask

  // Starts from an idle controller, so the first edge is the capture edge.
  task automatic cpu_access(input dc_op_e op, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err, output int lat);
    int n;
    n            = 0;
    req.addr     = addr;
    req.op       = op;
    data_down_in = wdata;
    cpu_req      = 1'b1;
    while (cpu_ack !== 1'b1) begin
      @(posedge clk);
      #1;
      n++;
    end
    rdata   = data_down_out;
    err     = cpu_err;
    lat     = n - 1;
    cpu_req = 1'b0;
    while (cpu_ack !== 1'b0) begin
      @(posedge clk);
      #1;
    end
    while (mem_ack !== 1'b0) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic load_check(input dc_op_e op, input logic [31:0] addr);
    logic [31:0] rdata;
    logic        err;
    int          lat;
    cpu_access(op, addr, 32'h0, rdata, err, lat);
    check("cpu_err", 1'b0, err);
    check("data_down_out", expected_load(op, addr, mem[addr[9:2]]), rdata);
  endtask

  task automatic store_check(input dc_op_e op, input logic [31:0] addr,
                             input logic [31:0] data);
    logic [31:0] rdata;
    logic [31:0] old_word;
    logic        err;
    int          lat;
    int          w0;
    old_word = mem[addr[9:2]];
    w0       = mem_writes;
    cpu_access(op, addr, data, rdata, err, lat);
    check("cpu_err", 1'b0, err);
    check("mem writes", w0 + 1, mem_writes);
    check("mem_cmd.be", expected_be(op, addr), last_be);
    check("mem_cmd.addr", addr >> 2, last_addr);
    check("memory word", merged_store(op, addr, old_word, data), mem[addr[9:2]]);
  endtask

  task automatic load_miss_then_hit();
    logic [31:0] rdata;
    logic        err;
    int          lat;
    int          start;
    int          m0;
    int          r0;
    start = errors;
    m0    = miss_count;
    r0    = mem_reads;
    cpu_access(OP_LW, 32'h40, 32'h0, rdata, err, lat);
    check("miss pulses", m0 + 1, miss_count);
    check("mem reads", r0 + 1, mem_reads);
    check("cpu_err", 1'b0, err);
    check("data_down_out", mem[16], rdata);
    r0 = mem_reads;
    cpu_access(OP_LW, 32'h40, 32'h0, rdata, err, lat);
    check("mem reads", r0, mem_reads);
    check("hit latency", 2, lat);
    check("data_down_out", mem[16], rdata);
    end_test("load miss then hit", start);
  endtask

  task automatic byte_half_alignment();
    int start;
    start   = errors;
    mem[35] = 32'h80f1_7e2c;  // Both byte and half signs in one word.
    for (int off = 0; off < 4; off++) begin
      load_check(OP_LB, 32'h8c + off);
      load_check(OP_LBU, 32'h8c + off);
      if (off % 2 == 0) begin
        load_check(OP_LH, 32'h8c + off);
        load_check(OP_LHU, 32'h8c + off);
      end
    end
    end_test("byte and half alignment", start);
  endtask

  task automatic write_through();
    int start;
    int r0;
    int m0;
    start = errors;
    store_check(OP_SB, 32'h41, 32'h1234_56a5);
    r0 = mem_reads;
    load_check(OP_LW, 32'h40);
    check("mem reads", r0, mem_reads);
    store_check(OP_SH, 32'hd6, 32'h9876_c3d4);
    m0 = miss_count;
    load_check(OP_LW, 32'hd4);
    check("miss pulses", m0 + 1, miss_count);
    store_check(OP_SW, 32'h48, 32'h0bad_f00d);
    end_test("write-through", start);
  endtask

  task automatic invalidate_and_disable();
    int start;
    int r0;
    int m0;
    start = errors;
    r0    = mem_reads;
    load_check(OP_LW, 32'h8c);
    check("mem reads", r0, mem_reads);
    invalidate = 1'b1;
    @(posedge clk);
    #1;
    invalidate = 1'b0;
    m0 = miss_count;
    load_check(OP_LW, 32'h8c);
    check("miss pulses", m0 + 1, miss_count);
    disable_cache = 1'b1;
    r0 = mem_reads;
    m0 = miss_count;
    load_check(OP_LW, 32'h8c);
    load_check(OP_LW, 32'h70);
    load_check(OP_LW, 32'h70);
    check("mem reads", r0 + 3, mem_reads);
    check("miss pulses", m0, miss_count);
    disable_cache = 1'b0;
    m0 = miss_count;
    load_check(OP_LW, 32'h70);
    check("miss pulses", m0 + 1, miss_count);
    end_test("invalidate and disable", start);
  endtask

  task automatic misaligned_access();
    logic [31:0] rdata;
    logic        err;
    int          lat;
    int          start;
    int          r0;
    int          w0;
    start = errors;
    r0    = mem_reads;
    w0    = mem_writes;
    cpu_access(OP_LH, 32'h41, 32'h0, rdata, err, lat);
    check("cpu_err", 1'b1, err);
    check("error latency", 2, lat);
    cpu_access(OP_SW, 32'h02, 32'hdead_beef, rdata, err, lat);
    check("cpu_err", 1'b1, err);
    check("error latency", 2, lat);
    check("mem reads", r0, mem_reads);
    check("mem writes", w0, mem_writes);
    end_test("misaligned access", start);
  endtask

  task automatic bus_passthrough();
    logic [31:0] rdata;
    logic [31:0] down;
    logic        err;
    int          lat;
    int          start;
    start = errors;
    for (int i = 0; i < 8; i++) begin
      up_bus       = $random(seed);
      data_down_in = $random(seed);
      @(posedge clk);
      #1;
      check("data_up_out", up_bus, data_up_out);
      check("data_down_out", data_down_in, data_down_out);
    end
    bus_stall = 1'b1;
    down      = $random(seed);
    cpu_access(OP_LW, 32'h8c, down, rdata, err, lat);
    check("data_down_out", down, rdata);
    bus_stall = 1'b0;
    end_test("bus passthrough and stall", start);
  endtask

  initial begin
    reset         = 1'b1;
    disable_cache = 1'b0;
    invalidate    = 1'b0;
    cpu_req       = 1'b0;
    req           = '0;
    bus_stall     = 1'b0;
    up_bus        = '0;
    data_down_in  = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(i);
    end
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    check("cpu_ack", 1'b0, cpu_ack);
    check("cpu_err", 1'b0, cpu_err);
    check("mem_req", 1'b0, mem_req);
    load_miss_then_hit();
    byte_half_alignment();
    write_through();
    invalidate_and_disable();
    misaligned_access();
    bus_passthrough();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dcache_bus.f */
verilog/dcache_pkg.sv
verilog/dcache_decode.sv
verilog/dcache_ctrl.sv
verilog/dcache_bus_mux.sv
verilog/dcache_bus.sv
dv/dcache_bus_props.sv
dv/dcache_bus_tb.sv
